//--- common/gb_seq_pkg.sv
`default_nettype none

package gb_seq_pkg;

    // Widths that carry a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  step_t;
    typedef logic [1:0]  cc_t;
    typedef logic [1:0]  flags_t;
    typedef logic [15:0] ctrl_t;

    // Scheduler FSM
    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_DISPATCH
    } sched_state_t;

    // Bit positions inside flags_t
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;

    // Condition codes, taken from opcode bits 4:3
    localparam cc_t CC_NZ = 2'd0;
    localparam cc_t CC_Z  = 2'd1;
    localparam cc_t CC_NC = 2'd2;
    localparam cc_t CC_C  = 2'd3;

    // Control word field positions
    localparam int ADDR_SEL_LSB = 0;
    localparam int REG_SEL_LSB  = 2;
    localparam int ALU_OP_LSB   = 5;
    localparam int IDU_OP_LSB   = 8;
    localparam int BUS_RD_BIT   = 10;
    localparam int BUS_WR_BIT   = 11;
    localparam int CC_CHECK_BIT = 12;
    localparam int EI_BIT       = 13;
    localparam int DI_BIT       = 14;
    localparam int VEC_WR_BIT   = 15;

    // Address bus source
    localparam logic [1:0] ADDR_PC  = 2'd0;
    localparam logic [1:0] ADDR_HL  = 2'd1;
    localparam logic [1:0] ADDR_SP  = 2'd2;
    localparam logic [1:0] ADDR_VEC = 2'd3;

    // Register select, WZ is the internal temp pair
    localparam logic [2:0] REG_B   = 3'd0;
    localparam logic [2:0] REG_HLM = 3'd6;
    localparam logic [2:0] REG_WZ  = 3'd7;

    // ALU / data path operations
    localparam logic [2:0] ALU_NOP   = 3'd0;
    localparam logic [2:0] ALU_LD    = 3'd1;
    localparam logic [2:0] ALU_ADD_E = 3'd2;
    localparam logic [2:0] ALU_CB    = 3'd3;
    localparam logic [2:0] ALU_PCH   = 3'd4;
    localparam logic [2:0] ALU_PCL   = 3'd5;
    localparam logic [2:0] ALU_JP    = 3'd6;

    // Incrementer / decrementer
    localparam logic [1:0] IDU_NONE = 2'd0;
    localparam logic [1:0] IDU_INC  = 2'd1;
    localparam logic [1:0] IDU_DEC  = 2'd2;

    // Single-bit masks, OR-ed onto a base word
    localparam ctrl_t M_BUS_RD   = ctrl_t'(1) << BUS_RD_BIT;
    localparam ctrl_t M_BUS_WR   = ctrl_t'(1) << BUS_WR_BIT;
    localparam ctrl_t M_CC_CHECK = ctrl_t'(1) << CC_CHECK_BIT;
    localparam ctrl_t M_EI       = ctrl_t'(1) << EI_BIT;
    localparam ctrl_t M_DI       = ctrl_t'(1) << DI_BIT;
    localparam ctrl_t M_VEC_WR   = ctrl_t'(1) << VEC_WR_BIT;

    // Read [PC] into IR, PC + 1
    localparam ctrl_t CTRL_FETCH = M_BUS_RD
                                 | (ctrl_t'(IDU_INC) << IDU_OP_LSB)
                                 | (ctrl_t'(ADDR_PC) << ADDR_SEL_LSB);

    // Interrupt sources and vectors
    localparam int    NUM_IRQ_DEFAULT = 5;
    localparam byte_t VEC_BASE        = 8'h40;
    localparam int    VEC_SPACING     = 8;

    // Supported opcodes
    localparam byte_t OP_NOP        = 8'h00;
    localparam byte_t OP_LD_B_N     = 8'h06;
    localparam byte_t OP_JR_CC_BASE = 8'h20;
    localparam byte_t OP_JR_CC_MASK = 8'hE7;
    localparam byte_t OP_CALL       = 8'hCD;
    localparam byte_t OP_EI         = 8'hFB;
    localparam byte_t OP_DI         = 8'hF3;
    localparam byte_t OP_CB         = 8'hCB;

    // Multi-bit fields of a control word, single bits are OR-ed on afterwards
    function automatic ctrl_t mk_ctrl(input logic [1:0] addr, input logic [2:0] rsel,
                                      input logic [2:0] alu, input logic [1:0] idu);
        ctrl_t c;
        c = '0;
        c[ADDR_SEL_LSB +: 2] = addr;
        c[REG_SEL_LSB +: 3]  = rsel;
        c[ALU_OP_LSB +: 3]   = alu;
        c[IDU_OP_LSB +: 2]   = idu;
        return c;
    endfunction

endpackage

`default_nettype wire

//--- decode/opcode_decoder.sv
`default_nettype none

module opcode_decoder (
    input  gb_seq_pkg::byte_t ir,
    input  logic              cb_mode,
    input  logic              isr_mode,
    input  gb_seq_pkg::step_t step,
    output gb_seq_pkg::ctrl_t ctrl,
    output gb_seq_pkg::step_t m_cycles,
    output gb_seq_pkg::cc_t   cc,
    output logic              cb_next
);

    // Word for the current execute step
    gb_seq_pkg::ctrl_t exec_w;

    always_comb begin
        exec_w   = '0;
        m_cycles = '0;
        cb_next  = 1'b0;
        if (isr_mode) begin
            // Dispatch: SP - 1, push PC high, push PC low, jump to vector
            m_cycles = 3'd4;
            case (step)
                3'd1: exec_w = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_SP, gb_seq_pkg::REG_WZ,
                                                   gb_seq_pkg::ALU_NOP, gb_seq_pkg::IDU_DEC);
                3'd2: exec_w = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_SP, gb_seq_pkg::REG_WZ,
                                                   gb_seq_pkg::ALU_PCH, gb_seq_pkg::IDU_DEC)
                             | gb_seq_pkg::M_BUS_WR;
                3'd3: exec_w = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_SP, gb_seq_pkg::REG_WZ,
                                                   gb_seq_pkg::ALU_PCL, gb_seq_pkg::IDU_NONE)
                             | gb_seq_pkg::M_BUS_WR;
                3'd4: exec_w = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_VEC, gb_seq_pkg::REG_WZ,
                                                   gb_seq_pkg::ALU_JP, gb_seq_pkg::IDU_NONE)
                             | gb_seq_pkg::M_VEC_WR;
                default: exec_w = '0;
            endcase
        end else if (cb_mode) begin
            // Register forms finish inside the fetch overlap
            if (ir[2:0] == gb_seq_pkg::REG_HLM) begin
                // (HL) form: read operand, then write result back
                m_cycles = 3'd2;
                case (step)
                    3'd1: exec_w = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_HL, gb_seq_pkg::REG_HLM,
                                                       gb_seq_pkg::ALU_CB, gb_seq_pkg::IDU_NONE)
                                 | gb_seq_pkg::M_BUS_RD;
                    3'd2: exec_w = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_HL, gb_seq_pkg::REG_HLM,
                                                       gb_seq_pkg::ALU_NOP, gb_seq_pkg::IDU_NONE)
                                 | gb_seq_pkg::M_BUS_WR;
                    default: exec_w = '0;
                endcase
            end
        end else if ((ir & gb_seq_pkg::OP_JR_CC_MASK) == gb_seq_pkg::OP_JR_CC_BASE) begin
            // JR cc,e: read offset and test cc, then add offset to PC
            m_cycles = 3'd2;
            case (step)
                3'd1: exec_w = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_PC, gb_seq_pkg::REG_WZ,
                                                   gb_seq_pkg::ALU_LD, gb_seq_pkg::IDU_INC)
                             | gb_seq_pkg::M_BUS_RD | gb_seq_pkg::M_CC_CHECK;
                3'd2: exec_w = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_PC, gb_seq_pkg::REG_WZ,
                                                   gb_seq_pkg::ALU_ADD_E, gb_seq_pkg::IDU_NONE);
                default: exec_w = '0;
            endcase
        end else begin
            case (ir)
                gb_seq_pkg::OP_NOP: m_cycles = 3'd0;
                gb_seq_pkg::OP_LD_B_N: begin
                    m_cycles = 3'd1;
                    exec_w   = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_PC, gb_seq_pkg::REG_B,
                                                   gb_seq_pkg::ALU_LD, gb_seq_pkg::IDU_INC)
                             | gb_seq_pkg::M_BUS_RD;
                end
                gb_seq_pkg::OP_CALL: begin
                    // Two operand reads, SP - 1, two pushes with the jump on the last
                    m_cycles = 3'd5;
                    exec_w   = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_SP, gb_seq_pkg::REG_WZ,
                                                   gb_seq_pkg::ALU_NOP, gb_seq_pkg::IDU_DEC);
                    if (step == 3'd1 || step == 3'd2) begin
                        exec_w = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_PC, gb_seq_pkg::REG_WZ,
                                                     gb_seq_pkg::ALU_LD, gb_seq_pkg::IDU_INC)
                               | gb_seq_pkg::M_BUS_RD;
                    end else if (step == 3'd4) begin
                        exec_w = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_SP, gb_seq_pkg::REG_WZ,
                                                     gb_seq_pkg::ALU_PCH, gb_seq_pkg::IDU_DEC)
                               | gb_seq_pkg::M_BUS_WR;
                    end else if (step == 3'd5) begin
                        exec_w = gb_seq_pkg::mk_ctrl(gb_seq_pkg::ADDR_SP, gb_seq_pkg::REG_WZ,
                                                     gb_seq_pkg::ALU_JP, gb_seq_pkg::IDU_NONE)
                               | gb_seq_pkg::M_BUS_WR;
                    end
                end
                // IME change lands at the end of the single execute cycle
                gb_seq_pkg::OP_EI: begin
                    m_cycles = 3'd1;
                    exec_w   = gb_seq_pkg::M_EI;
                end
                gb_seq_pkg::OP_DI: begin
                    m_cycles = 3'd1;
                    exec_w   = gb_seq_pkg::M_DI;
                end
                gb_seq_pkg::OP_CB: cb_next = 1'b1;
                // Unknown bytes behave as NOP
                default: m_cycles = 3'd0;
            endcase
        end
    end

    // Step 0 is always the fetch
    assign ctrl = (step == '0) ? gb_seq_pkg::CTRL_FETCH : exec_w;
    assign cc   = ir[4:3];

endmodule

`default_nettype wire

//--- irq/interrupt_unit.sv
`default_nettype none

module interrupt_unit #(
    parameter int NUM_IRQ = gb_seq_pkg::NUM_IRQ_DEFAULT
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [NUM_IRQ-1:0] irq_req,
    input  logic [NUM_IRQ-1:0] ie,
    input  logic               ei,
    input  logic               di,
    input  logic               dispatch_ack,
    output logic               irq_queued,
    output gb_seq_pkg::byte_t  vector
);

    logic [NUM_IRQ-1:0] flag_q;
    logic [NUM_IRQ-1:0] pending;
    logic [NUM_IRQ-1:0] clr_mask;
    logic               ime_q;
    // Wide enough for up to 8 sources
    logic [2:0]         sel_idx;

    assign pending    = flag_q & ie;
    assign irq_queued = ime_q && (|pending);

    // Priority encoder, lowest index wins
    always_comb begin
        sel_idx = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (pending[i]) sel_idx = 3'(i);
        end
    end

    // Acknowledge clears only the selected flag
    always_comb begin
        for (int i = 0; i < NUM_IRQ; i++) begin
            clr_mask[i] = dispatch_ack && (sel_idx == 3'(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag_q <= '0;
            ime_q  <= 1'b0;
            vector <= gb_seq_pkg::VEC_BASE;
        end else begin
            // A new request in the ack cycle is not lost
            flag_q <= (flag_q & ~clr_mask) | irq_req;
            if (dispatch_ack || di) begin
                ime_q <= 1'b0;
            end else if (ei) begin
                ime_q <= 1'b1;
            end
            // Vector held for the rest of the dispatch
            if (dispatch_ack) begin
                vector <= gb_seq_pkg::byte_t'(gb_seq_pkg::VEC_BASE
                                              + gb_seq_pkg::VEC_SPACING * sel_idx);
            end
        end
    end

endmodule

`default_nettype wire

//--- scheduler/m_cycle_scheduler.sv
`default_nettype none

module m_cycle_scheduler (
    input  logic               clk,
    input  logic               arst_n,
    input  gb_seq_pkg::byte_t  opcode,
    input  gb_seq_pkg::flags_t flags,
    input  gb_seq_pkg::ctrl_t  ctrl,
    input  gb_seq_pkg::step_t  m_cycles,
    input  gb_seq_pkg::cc_t    cc,
    input  logic               cb_next,
    input  logic               irq_queued,
    output gb_seq_pkg::byte_t  ir,
    output gb_seq_pkg::step_t  step,
    output logic               cb_mode,
    output logic               isr_mode,
    output logic               dispatch_ack,
    output logic               fetch
);

    gb_seq_pkg::sched_state_t state_q;
    gb_seq_pkg::step_t        step_q;
    gb_seq_pkg::byte_t        ir_q;
    logic                     cb_q;
    logic                     cond_met;
    logic                     cond_fail;
    logic                     last_step;
    logic                     take_irq;

    // Flag test for the current condition code
    always_comb begin
        case (cc)
            gb_seq_pkg::CC_NZ: cond_met = !flags[gb_seq_pkg::FLAG_Z];
            gb_seq_pkg::CC_Z:  cond_met = flags[gb_seq_pkg::FLAG_Z];
            gb_seq_pkg::CC_NC: cond_met = !flags[gb_seq_pkg::FLAG_C];
            default:           cond_met = flags[gb_seq_pkg::FLAG_C];
        endcase
    end

    assign cond_fail = ctrl[gb_seq_pkg::CC_CHECK_BIT] && !cond_met;
    // Instruction ends on its last step or on a failed condition
    assign last_step = (step_q == m_cycles) || cond_fail;
    // Never split the prefix from its opcode
    assign take_irq  = irq_queued && !cb_next;

    // During fetch the decoder looks at the incoming byte
    assign ir           = (state_q == gb_seq_pkg::S_FETCH) ? opcode : ir_q;
    assign step         = step_q;
    assign cb_mode      = cb_q;
    assign isr_mode     = (state_q == gb_seq_pkg::S_DISPATCH);
    assign fetch        = (state_q == gb_seq_pkg::S_FETCH);
    assign dispatch_ack = isr_mode && (step_q == 3'd1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= gb_seq_pkg::S_FETCH;
            step_q  <= '0;
            cb_q    <= 1'b0;
        end else begin
            case (state_q)
                gb_seq_pkg::S_FETCH: begin
                    if (take_irq) begin
                        // Fetched byte is dropped, dispatch runs instead
                        state_q <= gb_seq_pkg::S_DISPATCH;
                        step_q  <= 3'd1;
                        cb_q    <= 1'b0;
                    end else begin
                        // Prefix armed, or kept through a CB op with execute cycles
                        cb_q <= cb_next || (cb_q && (m_cycles != '0));
                        if (m_cycles != '0) begin
                            state_q <= gb_seq_pkg::S_EXEC;
                            step_q  <= 3'd1;
                        end
                    end
                end
                gb_seq_pkg::S_EXEC,
                gb_seq_pkg::S_DISPATCH: begin
                    if (last_step) begin
                        state_q <= gb_seq_pkg::S_FETCH;
                        step_q  <= '0;
                        cb_q    <= 1'b0;
                    end else begin
                        step_q <= step_q + 3'd1;
                    end
                end
                default: begin
                    state_q <= gb_seq_pkg::S_FETCH;
                    step_q  <= '0;
                end
            endcase
        end
    end

    // IR only loads when the fetched byte is kept
    always_ff @(posedge clk) begin
        if (state_q == gb_seq_pkg::S_FETCH && !take_irq) begin
            ir_q <= opcode;
        end
    end

endmodule

`default_nettype wire

//--- logic/gb_sequencer_top.sv
`default_nettype none

module gb_sequencer_top #(
    parameter int NUM_IRQ = gb_seq_pkg::NUM_IRQ_DEFAULT
) (
    input  logic               clk,
    input  logic               arst_n,
    input  gb_seq_pkg::byte_t  opcode,
    input  gb_seq_pkg::flags_t flags,
    input  logic [NUM_IRQ-1:0] irq_req,
    input  logic [NUM_IRQ-1:0] ie,
    output gb_seq_pkg::ctrl_t  ctrl,
    output logic               fetch,
    output logic               cb_active,
    output logic               isr_active,
    output gb_seq_pkg::byte_t  vector
);

    // Scheduler to decoder
    gb_seq_pkg::byte_t ir;
    gb_seq_pkg::step_t step;
    // Decoder to scheduler
    gb_seq_pkg::step_t m_cycles;
    gb_seq_pkg::cc_t   cc;
    logic              cb_next;
    // Interrupt handshake
    logic              irq_queued;
    logic              dispatch_ack;

    opcode_decoder u_decoder (
        .ir       (ir),
        .cb_mode  (cb_active),
        .isr_mode (isr_active),
        .step     (step),
        .ctrl     (ctrl),
        .m_cycles (m_cycles),
        .cc       (cc),
        .cb_next  (cb_next)
    );

    // EI / DI come straight from the live control word
    interrupt_unit #(
        .NUM_IRQ (NUM_IRQ)
    ) u_irq (
        .clk          (clk),
        .arst_n       (arst_n),
        .irq_req      (irq_req),
        .ie           (ie),
        .ei           (ctrl[gb_seq_pkg::EI_BIT]),
        .di           (ctrl[gb_seq_pkg::DI_BIT]),
        .dispatch_ack (dispatch_ack),
        .irq_queued   (irq_queued),
        .vector       (vector)
    );

    m_cycle_scheduler u_sched (
        .clk          (clk),
        .arst_n       (arst_n),
        .opcode       (opcode),
        .flags        (flags),
        .ctrl         (ctrl),
        .m_cycles     (m_cycles),
        .cc           (cc),
        .cb_next      (cb_next),
        .irq_queued   (irq_queued),
        .ir           (ir),
        .step         (step),
        .cb_mode      (cb_active),
        .isr_mode     (isr_active),
        .dispatch_ack (dispatch_ack),
        .fetch        (fetch)
    );

endmodule

`default_nettype wire

//--- tb/gb_sequencer_chk.sv
`default_nettype none

module gb_sequencer_chk (
    input logic              clk,
    input logic              arst_n,
    input logic              fetch,
    input gb_seq_pkg::ctrl_t ctrl,
    input gb_seq_pkg::step_t step,
    input gb_seq_pkg::step_t m_cycles
);

    // Vector jump only in the last dispatch step
    fetch_no_vec: assert property (@(posedge clk) disable iff (!arst_n)
        !(fetch && ctrl[gb_seq_pkg::VEC_WR_BIT]))
        else $error("fetch and vec_wr high together");

    ei_di_apart: assert property (@(posedge clk) disable iff (!arst_n)
        !(ctrl[gb_seq_pkg::EI_BIT] && ctrl[gb_seq_pkg::DI_BIT]))
        else $error("ei and di high together");

    // Step counter stays inside the schedule
    step_bound: assert property (@(posedge clk) disable iff (!arst_n)
        step <= m_cycles)
        else $error("step above m_cycles");

endmodule

bind m_cycle_scheduler gb_sequencer_chk u_chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .fetch    (fetch),
    .ctrl     (ctrl),
    .step     (step),
    .m_cycles (m_cycles)
);

`default_nettype wire

//--- tb/gb_sequencer_tb.sv
`default_nettype none

module gb_sequencer_tb;

    localparam int NUM_IRQ      = 5;
    localparam int RESET_CYCLES = 8;
    // Worst-case cycles per test, fetch plus longest schedule
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 + 200 * 6 + 16 * 3 + 40 * 4 + 6 * 100;
    localparam int LIMIT        = TEST_CYCLES * 40 * 2;

    logic               clk;
    logic               arst_n;
    logic [7:0]         opcode;
    logic [1:0]         flags;
    logic [NUM_IRQ-1:0] irq_req;
    logic [NUM_IRQ-1:0] ie;
    logic [15:0]        ctrl;
    logic               fetch;
    logic               cb_active;
    logic               isr_active;
    logic [7:0]         vector;

    // Reference model state, 0 fetch, 1 execute, 2 dispatch
    int                 m_state;
    int                 m_step;
    logic [7:0]         m_ir;
    logic               m_cb;
    logic               m_ime;
    logic [NUM_IRQ-1:0] m_flags;
    logic [7:0]         m_vec;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          tests_failed;
    int          tests_run;
    string       cur_test;
    logic [5:0]  exp_bits;
    logic [5:0]  got_bits;

    gb_sequencer_top #(.NUM_IRQ(NUM_IRQ)) uut (
        .clk(clk), .arst_n(arst_n), .opcode(opcode), .flags(flags),
        .irq_req(irq_req), .ie(ie), .ctrl(ctrl), .fetch(fetch),
        .cb_active(cb_active), .isr_active(isr_active), .vector(vector)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Execute cycles by the cycle-count table
    function automatic int exec_len(input logic [7:0] op, input logic cb);
        if (cb) return (op[2:0] == 3'b110) ? 2 : 0;
        if ((op & 8'hE7) == 8'h20) return 2;
        case (op)
            8'h06:        return 1;
            8'hCD:        return 5;
            8'hFB, 8'hF3: return 1;
            default:      return 0;
        endcase
    endfunction

    function automatic logic cond_ok(input logic [1:0] code, input logic [1:0] f);
        case (code)
            2'd0:    return !f[1];
            2'd1:    return f[1];
            2'd2:    return !f[0];
            default: return f[0];
        endcase
    endfunction

    function automatic int lowest(input logic [NUM_IRQ-1:0] m);
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (m[i]) return i;
        end
        return 0;
    endfunction

    // Expected {bus_rd, bus_wr, cc_check, ei, di, vec_wr}
    function automatic logic [5:0] word_bits(input int st, input int sp, input logic [7:0] op,
                                             input logic cb);
        if (st == 0) return 6'b100000;
        if (st == 2) return (sp == 4) ? 6'b000001 : ((sp == 2 || sp == 3) ? 6'b010000 : 6'b0);
        if (cb) return (sp == 1) ? 6'b100000 : 6'b010000;
        if ((op & 8'hE7) == 8'h20) return (sp == 1) ? 6'b101000 : 6'b000000;
        case (op)
            8'h06:   return 6'b100000;
            8'hCD:   return (sp <= 2) ? 6'b100000 : ((sp == 3) ? 6'b000000 : 6'b010000);
            8'hFB:   return 6'b000100;
            8'hF3:   return 6'b000010;
            default: return 6'b000000;
        endcase
    endfunction

    // Length the next fetch should lead to, dispatch included
    function automatic int exp_len_now(input logic [7:0] op);
        if (m_ime && (|(m_flags & ie)) && !(op == 8'hCB && !m_cb)) return 4;
        if (!m_cb && (op & 8'hE7) == 8'h20 && !cond_ok(op[4:3], flags)) return 1;
        return exec_len(op, m_cb);
    endfunction

    // Model advances on the same edge as the DUT
    always @(posedge clk or negedge arst_n) begin : model
        int  len;
        logic ack;
        logic cbn;
        logic [5:0] wb;
        if (!arst_n) begin
            m_state <= 0;
            m_step  <= 0;
            m_cb    <= 1'b0;
            m_ime   <= 1'b0;
            m_flags <= '0;
            m_vec   <= 8'h40;
        end else begin
            wb  = word_bits(m_state, m_step, m_ir, m_cb);
            ack = (m_state == 2) && (m_step == 1);
            cbn = (m_state == 0) && !m_cb && (opcode == 8'hCB);
            m_flags <= (m_flags & ~(ack ? (NUM_IRQ'(1) << lowest(m_flags & ie)) : '0)) | irq_req;
            if (ack || wb[1]) m_ime <= 1'b0;
            else if (wb[2]) m_ime <= 1'b1;
            if (ack) m_vec <= 8'h40 + 8'(8 * lowest(m_flags & ie));
            if (m_state == 0) begin
                if (m_ime && (|(m_flags & ie)) && !cbn) begin
                    m_state <= 2;
                    m_step  <= 1;
                    m_cb    <= 1'b0;
                end else begin
                    len  = exec_len(opcode, m_cb);
                    m_ir <= opcode;
                    m_cb <= cbn || (m_cb && len != 0);
                    if (len != 0) begin
                        m_state <= 1;
                        m_step  <= 1;
                    end
                end
            end else begin
                len = (m_state == 2) ? 4 : exec_len(m_ir, m_cb);
                if (m_step == len || (wb[3] && !cond_ok(m_ir[4:3], flags))) begin
                    m_state <= 0;
                    m_step  <= 0;
                    m_cb    <= 1'b0;
                end else begin
                    m_step <= m_step + 1;
                end
            end
        end
    end

    task automatic report(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("Mismatch %s %s: expected %0h actual %0h", cur_test, what, exp, act);
        errors++;
    endtask

    // Outputs compared mid-cycle, well away from both edges
    always @(negedge clk) begin
        exp_bits = word_bits(m_state, m_step, m_ir, m_cb);
        got_bits = {ctrl[10], ctrl[11], ctrl[12], ctrl[13], ctrl[14], ctrl[15]};
        checks++;
        if (fetch !== (m_state == 0)) report("fetch", 32'(m_state == 0), 32'(fetch));
        if (got_bits !== exp_bits) report("ctrl bits", 32'(exp_bits), 32'(got_bits));
        // Fetch word addresses through PC and increments it
        if (m_state == 0 && {ctrl[9:8], ctrl[1:0]} !== 4'b0100) begin
            report("fetch word", 32'(4'b0100), 32'({ctrl[9:8], ctrl[1:0]}));
        end
        if (cb_active !== m_cb) report("cb_active", 32'(m_cb), 32'(cb_active));
        if (isr_active !== (m_state == 2)) begin
            report("isr_active", 32'(m_state == 2), 32'(isr_active));
        end
        if (m_state == 2 && m_step >= 2 && vector !== m_vec) begin
            report("vector", 32'(m_vec), 32'(vector));
        end
    end

    // One instruction from its fetch cycle to the next fetch
    task automatic run_op(input logic [7:0] op, output int cycles);
        int cnt;
        int want;
        logic [31:0] r;
        cnt    = 0;
        want   = exp_len_now(op);
        opcode = op;
        @(posedge clk);
        #2;
        irq_req = '0;
        r       = next_rand();
        opcode  = r[7:0];
        while (!fetch && cnt < 16) begin
            cnt++;
            @(posedge clk);
            #2;
        end
        if (!fetch) begin
            $display("Timeout in %s: fetch did not come back after opcode %h", cur_test, op);
            errors++;
        end
        checks++;
        if (cnt != want) report("length", want, cnt);
        cycles = cnt;
    endtask

    task automatic close_test(input int err_before);
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("Test %-10s %s (%0d errors)", cur_test,
                 (errors == err_before) ? "ok" : "failed", errors - err_before);
    endtask

    // Dispatch whatever is enabled and pending, then leave the master enable off
    task automatic drain();
        int c;
        repeat (NUM_IRQ) begin
            if (|(m_flags & ie)) begin
                run_op(8'hFB, c);
                run_op(8'h00, c);
            end
        end
        run_op(8'hF3, c);
    endtask

    initial begin : watchdog
        #(LIMIT);
        $display("Watchdog: simulation ran past %0d time units", LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        int          e0;
        int          c;
        logic [31:0] r;
        logic [7:0]  op;
        logic [7:0]  want_vec;
        clk = 0;
        arst_n = 0;
        opcode = 8'h00;
        flags = 2'b00;
        irq_req = '0;
        ie = '0;
        rng = 32'd21801;
        errors = 0;
        checks = 0;
        tests_failed = 0;
        tests_run = 0;

        cur_test = "reset";
        e0 = errors;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1;
        @(posedge clk);
        #2;
        close_test(e0);

        cur_test = "counts";
        e0 = errors;
        repeat (200) begin
            r = next_rand();
            flags = r[9:8];
            case (r[2:0] % 3'd6)
                3'd0: op = 8'h00;
                3'd1: op = 8'h06;
                3'd2: op = 8'hCD;
                3'd3: op = 8'hFB;
                3'd4: op = 8'hF3;
                default: op = r[23:16];
            endcase
            if (op == 8'hCB || (op & 8'hE7) == 8'h20) op = 8'h00;
            run_op(op, c);
        end
        close_test(e0);

        cur_test = "jr_cc";
        e0 = errors;
        for (int code = 0; code < 4; code++) begin
            for (int f = 0; f < 4; f++) begin
                flags = 2'(f);
                op    = 8'h20 | 8'(code << 3);
                run_op(op, c);
                if (c != (cond_ok(2'(code), 2'(f)) ? 2 : 1))
                    report("jr length", cond_ok(2'(code), 2'(f)) ? 2 : 1, c);
            end
        end
        close_test(e0);

        cur_test = "prefix";
        e0 = errors;
        repeat (40) begin
            run_op(8'hCB, c);
            if (cb_active !== 1'b1) report("cb_active after prefix", 1, 32'(cb_active));
            r  = next_rand();
            op = r[7:0];
            run_op(op, c);
            if (c != ((op[2:0] == 3'b110) ? 2 : 0))
                report("cb length", (op[2:0] == 3'b110) ? 2 : 0, c);
            if (cb_active !== 1'b0) report("cb_active after op", 0, 32'(cb_active));
        end
        close_test(e0);

        cur_test = "irq";
        e0 = errors;
        repeat (6) begin
            r  = next_rand();
            ie = r[NUM_IRQ-1:0];
            if (ie == '0) ie = 5'b00001;
            run_op(8'hF3, c);
            r       = next_rand();
            irq_req = r[NUM_IRQ-1:0] & ie;
            if (irq_req == '0) irq_req = ie & ~(ie - 5'd1);
            run_op(8'h00, c);
            run_op(8'hFB, c);
            want_vec = 8'h40 + 8'(8 * lowest(m_flags & ie));
            run_op(8'h00, c);
            if (c != 4) report("dispatch length", 4, c);
            if (vector !== want_vec) report("dispatch vector", 32'(want_vec), 32'(vector));
            run_op(8'h00, c);
            if (c != 0) report("second dispatch without EI", 0, c);
            drain();
            // Master enable set by EI, then cleared by DI
            run_op(8'hFB, c);
            run_op(8'hF3, c);
            irq_req = ie;
            run_op(8'h00, c);
            run_op(8'h00, c);
            if (c != 0) report("dispatch after DI", 0, c);
            drain();
            // Masked by ie
            ie = '0;
            r  = next_rand();
            irq_req = r[NUM_IRQ-1:0];
            if (irq_req == '0) irq_req = '1;
            run_op(8'h00, c);
            run_op(8'hFB, c);
            run_op(8'h00, c);
            if (c != 0) report("dispatch with ie clear", 0, c);
            run_op(8'hF3, c);
        end
        close_test(e0);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- gb_sequencer_top.f
common/gb_seq_pkg.sv
decode/opcode_decoder.sv
irq/interrupt_unit.sv
scheduler/m_cycle_scheduler.sv
logic/gb_sequencer_top.sv
tb/gb_sequencer_chk.sv
tb/gb_sequencer_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= gb_sequencer_tb
FILELIST  ?= gb_sequencer_top.f
LOG       ?= sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
